// File: if_macros.svh
/*
  Instruction fetch stage constants
  Widths, FIFO depth and branch target buffer geometry
*/
`ifndef IF_MACROS_SVH
`define IF_MACROS_SVH

// Address and instruction word width
`define IF_XLEN 32

// Branch target buffer geometry, index is PC[4:2]
`define IF_BTB_ENTRIES 8
`define IF_BTB_IDX_W 3

// Fetch FIFO depth, also the outstanding transaction limit
`define IF_FIFO_DEPTH 2

// Zero bits appended below mtvec base
`define IF_MTVEC_ALIGN 7

// addi x0, x0, 0
`define IF_RESET_INSTR 32'h0000_0013

`endif

// File: if_pkg.sv
/*
  Instruction fetch package
  Next-PC select codes, predictor commands and fetch response type
*/
`default_nettype none

`include "if_macros.svh"

package if_pkg;

  // Fetch address
  typedef logic [`IF_XLEN-1:0] addr_t;

  // Next-PC source chosen by the controller
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_MRET      = 3'd3,
    PC_TRAP      = 3'd4,
    PC_PREDICTED = 3'd5
  } pc_mux_e;

  // Predictor update command from EX
  typedef enum logic [1:0] {
    BTB_NONE      = 2'd0,
    BTB_TAKEN     = 2'd1,
    BTB_NOT_TAKEN = 2'd2,
    BTB_FLUSH     = 2'd3
  } btb_cmd_e;

  // One bus response, word plus error flag
  typedef struct packed {
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } fetch_resp_t;

endpackage

`default_nettype wire

// File: if_pc_mux.sv
/*
  Next-PC multiplexer
  Picks the redirect target from the controller's selection
  and raises the mtvec init pulse at boot
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_pc_mux
  import if_pkg::*;
(
  input  logic                                   pc_set_i,
  input  pc_mux_e                                pc_mux_i,
  input  addr_t                                  boot_addr_i,
  input  addr_t                                  jump_target_i,
  input  addr_t                                  branch_target_i,
  input  addr_t                                  mepc_i,
  input  logic [`IF_XLEN-`IF_MTVEC_ALIGN-1:0]    mtvec_addr_i,
  input  addr_t                                  pred_target_i,
  output addr_t                                  branch_addr_o,
  output logic                                   csr_mtvec_init_o
);

  // Raw target before halfword alignment
  addr_t target;

  always_comb begin
    case (pc_mux_i)
      // Boot address is forced onto a word boundary
      PC_BOOT:      target = {boot_addr_i[`IF_XLEN-1:2], 2'b00};
      PC_JUMP:      target = jump_target_i;
      PC_BRANCH:    target = branch_target_i;
      // Return from trap
      PC_MRET:      target = mepc_i;
      // Non-vectored trap base
      PC_TRAP:      target = {mtvec_addr_i, {`IF_MTVEC_ALIGN{1'b0}}};
      PC_PREDICTED: target = pred_target_i;
      default:      target = {boot_addr_i[`IF_XLEN-1:2], 2'b00};
    endcase
  end

  // Bit 0 is never set in a fetch address
  assign branch_addr_o = {target[`IF_XLEN-1:1], 1'b0};

  // CSR file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

// File: if_fifo.sv
/*
  Small synchronous FIFO
  Circular buffer of IF_FIFO_DEPTH entries, payload type set by T
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_fifo #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int DEPTH = `IF_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Pointer step with wrap at the last slot
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  // Head entry, only meaningful when not empty
  assign data_o  = mem_q[rd_ptr_q];

  //////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Flush wins over push and pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Overflow and underflow are the caller's bugs
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_i && !flush_i) |-> !empty_o);

endmodule

`default_nettype wire

// File: if_fetch_unit.sv
/*
  Fetch unit
  Issues sequential word requests on the instruction bus, tracks
  outstanding transactions, drops responses made stale by a redirect
  and presents each surviving word with its address
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_fetch_unit
  import if_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pc_set_i,
  input  logic                kill_i,
  input  addr_t               branch_addr_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i,
  input  logic                fetch_ready_i,
  output logic                instr_req_o,
  output addr_t               instr_addr_o,
  output logic                fetch_valid_o,
  output fetch_resp_t         fetch_resp_o,
  output addr_t               fetch_pc_o,
  output logic                busy_o
);

  localparam int DEPTH = `IF_FIFO_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Next address to request
  addr_t            fetch_addr_q;
  // Fetching enabled, set by the first redirect
  logic             active_q;
  // All bus transactions in flight, stale ones included
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] out_cnt_n;
  // Responses still to be thrown away
  logic [CNT_W-1:0] drop_cnt_q;

  logic             redirect;
  logic             grant;
  logic             resp_drop;
  logic             resp_keep;
  logic             transfer;
  logic             addr_empty;
  logic             addr_full;
  logic             resp_empty;
  logic             resp_full;
  fetch_resp_t      resp_in;

  assign redirect  = pc_set_i || kill_i;
  assign grant     = instr_req_o && instr_gnt_i;
  assign resp_drop = instr_rvalid_i && (drop_cnt_q != '0);
  assign resp_keep = instr_rvalid_i && (drop_cnt_q == '0);
  assign transfer  = fetch_valid_o && fetch_ready_i;
  assign resp_in   = {instr_rdata_i, instr_err_i};

  //////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////
  // Held off during a redirect so no old address is granted then
  // Address FIFO not full means the response FIFO has room for all
  assign instr_req_o  = active_q && !redirect && !addr_full && !resp_full &&
                        (out_cnt_q < CNT_W'(DEPTH));
  assign instr_addr_o = fetch_addr_q;

  // In-flight count after this cycle
  always_comb begin
    out_cnt_n = out_cnt_q;
    if (grant && !instr_rvalid_i) begin
      out_cnt_n = out_cnt_q + 1'b1;
    end else if (!grant && instr_rvalid_i) begin
      out_cnt_n = out_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      if (pc_set_i) begin
        active_q     <= 1'b1;
        fetch_addr_q <= branch_addr_i;
      end else if (kill_i) begin
        // Kill alone parks fetching until the next pc_set
        active_q <= 1'b0;
      end else if (grant) begin
        fetch_addr_q <= fetch_addr_q + `IF_XLEN'd4;
      end
      // Everything still in flight at a redirect is stale
      if (redirect) begin
        drop_cnt_q <= out_cnt_n;
      end else if (resp_drop) begin
        drop_cnt_q <= drop_cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Address and response queues
  //////////////////////////////////////////////////
  // Address pushed at grant, paired with its response at the head
  if_fifo #(.T(addr_t)) addr_fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (redirect),
    .push_i  (grant),
    .data_i  (fetch_addr_q),
    .pop_i   (transfer),
    .data_o  (fetch_pc_o),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  if_fifo #(.T(fetch_resp_t)) resp_fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (redirect),
    .push_i  (resp_keep),
    .data_i  (resp_in),
    .pop_i   (transfer),
    .data_o  (fetch_resp_o),
    .empty_o (resp_empty),
    .full_o  (resp_full)
  );

  assign fetch_valid_o = !resp_empty;
  assign busy_o        = (out_cnt_q != '0) || !addr_empty || !resp_empty;

  // Waiting request keeps its address until granted
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> $stable(instr_addr_o));

endmodule

`default_nettype wire

// File: if_branch_predictor.sv
/*
  Branch target buffer
  Direct-mapped table with 2-bit history counters,
  combinational lookup on the IF PC and clocked update from EX
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_branch_predictor
  import if_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  addr_t    pc_if_i,
  input  btb_cmd_e btb_cmd_i,
  input  addr_t    pc_ex_i,
  input  addr_t    target_ex_i,
  output logic     hit_o,
  output logic     prediction_o,
  output addr_t    target_o
);

  localparam int ENTRIES = `IF_BTB_ENTRIES;
  localparam int IDX_W   = `IF_BTB_IDX_W;
  localparam int TAG_W   = `IF_XLEN - IDX_W - 2;

  // Table state
  logic [ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]   tag_q    [ENTRIES];
  addr_t              target_q [ENTRIES];
  logic [1:0]         cnt_q    [ENTRIES];

  logic [IDX_W-1:0]   if_idx;
  logic [TAG_W-1:0]   if_tag;
  logic [IDX_W-1:0]   ex_idx;
  logic [TAG_W-1:0]   ex_tag;
  logic               ex_match;
  logic               update;

  // Word index above the byte offset, tag above the index
  assign if_idx = pc_if_i[IDX_W+1:2];
  assign if_tag = pc_if_i[`IF_XLEN-1:IDX_W+2];
  assign ex_idx = pc_ex_i[IDX_W+1:2];
  assign ex_tag = pc_ex_i[`IF_XLEN-1:IDX_W+2];

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign hit_o        = valid_q[if_idx] && (tag_q[if_idx] == if_tag);
  // Counter MSB means taken
  assign prediction_o = hit_o && cnt_q[if_idx][1];
  assign target_o     = hit_o ? target_q[if_idx] : '0;

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////
  assign update   = (btb_cmd_i == BTB_TAKEN) || (btb_cmd_i == BTB_NOT_TAKEN);
  assign ex_match = valid_q[ex_idx] && (tag_q[ex_idx] == ex_tag);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (btb_cmd_i == BTB_FLUSH) begin
      valid_q <= '0;
    end else if (update) begin
      valid_q[ex_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (update) begin
      if (!ex_match) begin
        // Allocate, replacing whatever lived in this slot
        // Weakly taken or weakly not-taken start
        tag_q[ex_idx]    <= ex_tag;
        target_q[ex_idx] <= target_ex_i;
        cnt_q[ex_idx]    <= (btb_cmd_i == BTB_TAKEN) ? 2'd2 : 2'd1;
      end else if (btb_cmd_i == BTB_TAKEN) begin
        // Taken refreshes the target, counter saturates at 3
        target_q[ex_idx] <= target_ex_i;
        if (cnt_q[ex_idx] != 2'd3) begin
          cnt_q[ex_idx] <= cnt_q[ex_idx] + 2'd1;
        end
      end else begin
        // Not taken, saturates at 0
        if (cnt_q[ex_idx] != 2'd0) begin
          cnt_q[ex_idx] <= cnt_q[ex_idx] - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: if_stage.sv
/*
  Instruction fetch stage top
  Next-PC mux, fetch unit and branch target buffer,
  plus the IF/ID pipeline register toward decode
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_stage
  import if_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  // Controller
  input  logic                                pc_set_i,
  input  pc_mux_e                             pc_mux_i,
  input  addr_t                               boot_addr_i,
  input  addr_t                               jump_target_i,
  input  addr_t                               branch_target_i,
  input  addr_t                               mepc_i,
  input  logic [`IF_XLEN-`IF_MTVEC_ALIGN-1:0] mtvec_addr_i,
  input  logic                                halt_i,
  input  logic                                kill_i,
  // Predictor update from EX
  input  btb_cmd_e                            btb_cmd_i,
  input  addr_t                               pc_ex_i,
  // Instruction bus
  output logic                                instr_req_o,
  output addr_t                               instr_addr_o,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0]                 instr_rdata_i,
  input  logic                                instr_err_i,
  // Decode side
  input  logic                                id_ready_i,
  output logic                                id_valid_o,
  output addr_t                               id_pc_o,
  output logic [`IF_XLEN-1:0]                 id_instr_o,
  output logic                                id_err_o,
  output logic                                id_hit_o,
  output logic                                id_prediction_o,
  output addr_t                               id_target_o,
  // Status
  output addr_t                               pc_if_o,
  output logic                                if_busy_o,
  output logic                                csr_mtvec_init_o
);

  addr_t       branch_addr;
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_resp_t fetch_resp;
  addr_t       fetch_pc;
  logic        pred_hit;
  logic        pred_taken;
  addr_t       pred_target;
  logic        load_id;

  if_pc_mux pc_mux_inst (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .pred_target_i    (pred_target),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // Decode pulls words only when ready and not halted
  assign fetch_ready = id_ready_i && !halt_i;

  if_fetch_unit fetch_unit_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .kill_i         (kill_i),
    .branch_addr_i  (branch_addr),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fetch_ready_i  (fetch_ready),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .fetch_valid_o  (fetch_valid),
    .fetch_resp_o   (fetch_resp),
    .fetch_pc_o     (fetch_pc),
    .busy_o         (if_busy_o)
  );

  assign pc_if_o = fetch_pc;

  // Lookup on the word now at the head of the fetch queue
  // Taken branch target comes from EX
  if_branch_predictor branch_predictor_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_if_i      (fetch_pc),
    .btb_cmd_i    (btb_cmd_i),
    .pc_ex_i      (pc_ex_i),
    .target_ex_i  (branch_target_i),
    .hit_o        (pred_hit),
    .prediction_o (pred_taken),
    .target_o     (pred_target)
  );

  //////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////
  assign load_id = fetch_valid && id_ready_i && !halt_i && !kill_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o      <= 1'b0;
      id_pc_o         <= '0;
      id_instr_o      <= `IF_RESET_INSTR;
      id_err_o        <= 1'b0;
      id_hit_o        <= 1'b0;
      id_prediction_o <= 1'b0;
      id_target_o     <= '0;
    end else if (kill_i) begin
      // Kill empties the slot, payload keeps its last value
      id_valid_o <= 1'b0;
    end else if (load_id) begin
      id_valid_o      <= 1'b1;
      id_pc_o         <= fetch_pc;
      id_instr_o      <= fetch_resp.rdata;
      id_err_o        <= fetch_resp.err;
      id_hit_o        <= pred_hit;
      id_prediction_o <= pred_taken;
      id_target_o     <= pred_target;
    end else if (id_ready_i) begin
      // Decode consumed the word and nothing replaced it
      id_valid_o <= 1'b0;
    end
  end

  a_id_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(id_valid_o));

endmodule

`default_nettype wire

// File: if_checker.sv
/*
  Fetch stage checker
  Watches the DUT ports, rebuilds the expected PC stream and
  mirrors the branch target buffer, then compares the ID outputs
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module if_checker
  import if_pkg::*;
(
  input logic                                clk,
  input logic                                rst_n,
  input logic                                pc_set_i,
  input pc_mux_e                             pc_mux_i,
  input logic [31:0]                         boot_addr_i,
  input logic [31:0]                         jump_target_i,
  input logic [31:0]                         branch_target_i,
  input logic [31:0]                         mepc_i,
  input logic [`IF_XLEN-`IF_MTVEC_ALIGN-1:0] mtvec_addr_i,
  input logic                                halt_i,
  input logic                                kill_i,
  input btb_cmd_e                            btb_cmd_i,
  input logic [31:0]                         pc_ex_i,
  input logic                                instr_req_o,
  input logic                                instr_gnt_i,
  input logic                                instr_rvalid_i,
  input logic                                id_ready_i,
  input logic                                id_valid_o,
  input logic [31:0]                         id_pc_o,
  input logic [31:0]                         id_instr_o,
  input logic                                id_err_o,
  input logic                                id_hit_o,
  input logic                                id_prediction_o,
  input logic [31:0]                         id_target_o,
  input logic [31:0]                         pc_if_o,
  input logic                                if_busy_o,
  input logic                                csr_mtvec_init_o
);

  int          consumed = 0;
  int          err_count = 0;
  int          check_count = 0;
  logic [31:0] exp_pc = '0;

  // Predictor model
  logic        m_valid  [`IF_BTB_ENTRIES];
  logic [26:0] m_tag    [`IF_BTB_ENTRIES];
  logic [31:0] m_target [`IF_BTB_ENTRIES];
  logic [1:0]  m_cnt    [`IF_BTB_ENTRIES];
  logic [2:0]  u_idx;
  logic [2:0]  l_idx;
  logic        l_hit;

  // Held ID outputs while decode stalls
  logic        hold_pend = 1'b0;
  logic        kill_seen = 1'b0;
  logic [31:0] h_pc;
  logic [31:0] h_instr;
  logic        h_err;
  logic        h_hit;
  logic        h_pred;
  logic [31:0] h_target;

  // Bus transactions granted and not yet answered
  int          out_m = 0;
  // No fetch activity before the first redirect
  logic        booted = 1'b0;
  // IF/ID register could load at the last edge
  logic        ld_q = 1'b0;
  logic [31:0] pc_if_q;

  // Redirect target as the controller defines it
  function automatic logic [31:0] expected_target(input pc_mux_e sel);
    logic [31:0] t;
    case (sel)
      PC_JUMP:   t = jump_target_i;
      PC_BRANCH: t = branch_target_i;
      PC_MRET:   t = mepc_i;
      PC_TRAP:   t = {mtvec_addr_i, 7'b0};
      default:   t = {boot_addr_i[31:2], 2'b00};
    endcase
    return {t[31:1], 1'b0};
  endfunction

  // Memory contents and error window, same rule as the bus model
  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ (a >> 7) ^ 32'h5A5A_0000;
  endfunction

  function automatic logic expected_err(input logic [31:0] a);
    return a[31:6] == 26'h80;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `IF_BTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
      end
      hold_pend = 1'b0;
      kill_seen = 1'b0;
      ld_q      = 1'b0;
      booted    = 1'b0;
      out_m     = 0;
    end else begin
      check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
                  32'(pc_set_i && (pc_mux_i == PC_BOOT)));
      // Stage stays quiet until the boot jump
      if (!booted) begin
        check_value("instr_req_o", 32'(instr_req_o), 32'd0);
        check_value("if_busy_o", 32'(if_busy_o), 32'd0);
        check_value("id_valid_o", 32'(id_valid_o), 32'd0);
      end
      // Busy while a granted request still waits for its response
      if (out_m != 0) begin
        check_value("if_busy_o", 32'(if_busy_o), 32'd1);
      end
      // Outstanding limit on the bus
      if (out_m >= `IF_FIFO_DEPTH) begin
        check_value("instr_req_o", 32'(instr_req_o), 32'd0);
      end
      // Slot must be empty right after a kill
      if (kill_seen) begin
        check_value("id_valid_o", 32'(id_valid_o), 32'd0);
      end
      if (hold_pend) begin
        check_value("id_pc_o (hold)", id_pc_o, h_pc);
        check_value("id_instr_o (hold)", id_instr_o, h_instr);
        check_value("id_err_o (hold)", 32'(id_err_o), 32'(h_err));
        check_value("id_hit_o (hold)", 32'(id_hit_o), 32'(h_hit));
        check_value("id_prediction_o (hold)", 32'(id_prediction_o), 32'(h_pred));
        check_value("id_target_o (hold)", id_target_o, h_target);
      end
      // Fresh load, IF PC at that edge is the word now in the slot
      if (ld_q && id_valid_o) begin
        check_value("pc_if_o", pc_if_q, exp_pc);
      end
      //////////////////////////////////////////////////
      // Word taken by decode
      //////////////////////////////////////////////////
      if (id_valid_o && id_ready_i && !kill_i) begin
        consumed++;
        l_idx = id_pc_o[4:2];
        l_hit = m_valid[l_idx] && (m_tag[l_idx] == id_pc_o[31:5]);
        check_value("id_pc_o", id_pc_o, exp_pc);
        check_value("id_err_o", 32'(id_err_o), 32'(expected_err(exp_pc)));
        if (!expected_err(exp_pc)) begin
          check_value("id_instr_o", id_instr_o, expected_word(exp_pc));
        end
        check_value("id_hit_o", 32'(id_hit_o), 32'(l_hit));
        check_value("id_prediction_o", 32'(id_prediction_o), 32'(l_hit && m_cnt[l_idx][1]));
        if (l_hit) begin
          check_value("id_target_o", id_target_o, m_target[l_idx]);
        end
        exp_pc = exp_pc + 32'd4;
      end
      hold_pend = id_valid_o && !id_ready_i && !kill_i;
      h_pc      = id_pc_o;
      h_instr   = id_instr_o;
      h_err     = id_err_o;
      h_hit     = id_hit_o;
      h_pred    = id_prediction_o;
      h_target  = id_target_o;
      kill_seen = kill_i;
      ld_q      = id_ready_i && !halt_i && !kill_i && !pc_set_i;
      pc_if_q   = pc_if_o;
      // In-flight count from the bus handshake
      if (instr_req_o && instr_gnt_i) begin
        out_m = out_m + 1;
      end
      if (instr_rvalid_i) begin
        out_m = out_m - 1;
      end
      // Table update mirrors the EX command
      u_idx = pc_ex_i[4:2];
      if (btb_cmd_i == BTB_FLUSH) begin
        for (int i = 0; i < `IF_BTB_ENTRIES; i++) begin
          m_valid[i] = 1'b0;
        end
      end else if (btb_cmd_i != BTB_NONE) begin
        if (m_valid[u_idx] && (m_tag[u_idx] == pc_ex_i[31:5])) begin
          if (btb_cmd_i == BTB_TAKEN) begin
            m_target[u_idx] = branch_target_i;
            m_cnt[u_idx]    = (m_cnt[u_idx] == 2'd3) ? 2'd3 : m_cnt[u_idx] + 2'd1;
          end else begin
            m_cnt[u_idx] = (m_cnt[u_idx] == 2'd0) ? 2'd0 : m_cnt[u_idx] - 2'd1;
          end
        end else begin
          m_valid[u_idx]  = 1'b1;
          m_tag[u_idx]    = pc_ex_i[31:5];
          m_target[u_idx] = branch_target_i;
          m_cnt[u_idx]    = (btb_cmd_i == BTB_TAKEN) ? 2'd2 : 2'd1;
        end
      end
      if (pc_set_i) begin
        exp_pc = expected_target(pc_mux_i);
        booted = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_if_stage.sv
/*
  Fetch stage testbench
  Clock, reset, random-grant bus memory and falling-edge stimulus
*/
`timescale 1ns/1ps
`default_nettype none

`include "if_macros.svh"

module tb_if_stage
  import if_pkg::*;
;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  logic [31:0] boot_addr_i;
  logic [31:0] jump_target_i;
  logic [31:0] branch_target_i;
  logic [31:0] mepc_i;
  logic [24:0] mtvec_addr_i;
  logic        halt_i;
  logic        kill_i;
  btb_cmd_e    btb_cmd_i;
  logic [31:0] pc_ex_i;
  logic        instr_gnt_i = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i = '0;
  logic        instr_err_i = 1'b0;
  logic        id_ready_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        id_valid_o;
  logic [31:0] id_pc_o;
  logic [31:0] id_instr_o;
  logic        id_err_o;
  logic        id_hit_o;
  logic        id_prediction_o;
  logic [31:0] id_target_o;
  logic [31:0] pc_if_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;

  integer      seed = 32'h4259;
  integer      bus_seed = 32'h4259;
  logic [31:0] r;
  logic [31:0] rb;
  logic        timed_out = 1'b0;
  int          cycle = 0;
  logic [31:0] pend_addr [$];
  int          pend_due [$];

  always #5 clk = ~clk;

  if_stage if_stage_inst (.*);

  if_checker checker_inst (.*);

  //////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ (a >> 7) ^ 32'h5A5A_0000;
  endfunction

  // Accepted address, reply due 0 to 3 cycles later
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst_n && instr_req_o && instr_gnt_i) begin
      rb = $random(bus_seed);
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cycle + int'(rb[1:0]));
    end
  end

  always @(negedge clk) begin
    rb = $random(bus_seed);
    instr_gnt_i = rst_n && (rb[0] || rb[1]);
    instr_rvalid_i = 1'b0;
    if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_word(pend_addr[0]);
      // Error window 0x2000 to 0x203f
      instr_err_i    = (pend_addr[0][31:6] == 26'h80);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  task automatic redirect(input pc_mux_e sel);
    @(negedge clk);
    pc_set_i = 1'b1;
    kill_i   = 1'b1;
    pc_mux_i = sel;
    @(negedge clk);
    pc_set_i = 1'b0;
    kill_i   = 1'b0;
  endtask

  // Waits for n more words taken by decode, random ready and halt if asked
  task automatic wait_words(input int n, input logic rand_mode);
    int target;
    int cnt;
    target = checker_inst.consumed + n;
    cnt = 0;
    while (!timed_out && checker_inst.consumed < target) begin
      @(negedge clk);
      if (rand_mode) begin
        r = $random(seed);
        id_ready_i = r[0] || r[1];
        halt_i     = r[2] && r[3];
      end
      cnt++;
      if (cnt > 3000) begin
        $display("Timeout: decode received %0d of %0d words",
                 n - (target - checker_inst.consumed), n);
        timed_out = 1'b1;
      end
    end
    id_ready_i = 1'b1;
    halt_i     = 1'b0;
  endtask

  // Halt fetch and let decode empty the IF/ID slot
  task automatic halt_and_drain();
    int cnt;
    cnt = 0;
    @(negedge clk);
    halt_i = 1'b1;
    while (!timed_out && id_valid_o) begin
      @(negedge clk);
      cnt++;
      if (cnt > 50) begin
        $display("Timeout: IF/ID register did not empty under halt");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic btb_update(input btb_cmd_e cmd, input logic [31:0] pc, input logic [31:0] tgt);
    @(negedge clk);
    btb_cmd_i       = cmd;
    pc_ex_i         = pc;
    branch_target_i = tgt;
    @(negedge clk);
    btb_cmd_i = BTB_NONE;
  endtask

  task automatic end_of_test();
    $display("Checks: %0d, errors: %0d, words: %0d, timeout: %0d", checker_inst.check_count,
             checker_inst.err_count, checker_inst.consumed, timed_out);
    if (!timed_out && checker_inst.err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    rst_n = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    boot_addr_i = 32'h0000_1002;
    jump_target_i = 32'h0000_1800;
    branch_target_i = 32'h0000_1900;
    mepc_i = 32'h0000_1A04;
    mtvec_addr_i = 25'h40;
    halt_i = 1'b0;
    kill_i = 1'b0;
    btb_cmd_i = BTB_NONE;
    pc_ex_i = '0;
    id_ready_i = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // Boot and straight-line fetch
    redirect(PC_BOOT);
    wait_words(12, 1'b0);
    // Each redirect source, words still in flight
    redirect(PC_JUMP);
    wait_words(3, 1'b0);
    redirect(PC_BRANCH);
    wait_words(3, 1'b0);
    redirect(PC_MRET);
    wait_words(3, 1'b0);
    // Trap base lands in the error window and runs past it
    redirect(PC_TRAP);
    wait_words(20, 1'b0);
    // Random back-pressure and halt
    jump_target_i = 32'h0000_3000;
    redirect(PC_JUMP);
    wait_words(40, 1'b1);
    // Kill alone parks fetching, decode stalled so only kill empties the slot
    @(negedge clk);
    kill_i     = 1'b1;
    id_ready_i = 1'b0;
    @(negedge clk);
    kill_i     = 1'b0;
    id_ready_i = 1'b1;
    repeat (3) @(negedge clk);
    jump_target_i = 32'h0000_1400;
    redirect(PC_JUMP);
    wait_words(4, 1'b0);
    // Predictor training under halt
    halt_and_drain();
    btb_update(BTB_TAKEN, 32'h0000_1404, 32'h0000_1800);
    btb_update(BTB_NOT_TAKEN, 32'h0000_1408, 32'h0000_1000);
    btb_update(BTB_TAKEN, 32'h0000_1410, 32'h0000_1A00);
    btb_update(BTB_TAKEN, 32'h0000_1404, 32'h0000_1804);
    btb_update(BTB_NOT_TAKEN, 32'h0000_1410, 32'h0000_1000);
    redirect(PC_JUMP);
    halt_i = 1'b0;
    wait_words(8, 1'b0);
    // Conflicting tag replaces slot 1, then flush
    halt_and_drain();
    btb_update(BTB_TAKEN, 32'h0000_3424, 32'h0000_2200);
    redirect(PC_JUMP);
    halt_i = 1'b0;
    wait_words(8, 1'b0);
    halt_and_drain();
    btb_update(BTB_FLUSH, 32'h0000_0000, 32'h0000_0000);
    btb_update(BTB_TAKEN, 32'h0000_1408, 32'h0000_1C00);
    redirect(PC_JUMP);
    halt_i = 1'b0;
    wait_words(6, 1'b1);
    repeat (5) @(negedge clk);
    end_of_test();
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
if_pkg.sv
if_pc_mux.sv
if_fifo.sv
if_fetch_unit.sv
if_branch_predictor.sv
if_stage.sv
if_checker.sv
tb_if_stage.sv

// File: run.sh
#!/bin/bash
# Builds the fetch stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_if_stage -o sim_if_stage \
  && ./obj_dir/sim_if_stage > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qF '** FAIL **' sim.log && exit 1 || exit 0
